// ==== Bender.yml ====
package:
  name: cpu64

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/cpu_regfile.sv
      - source/cpu_alu.sv
      - source/cpu_bus_master.sv
      - source/cpu_control.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - source
      - verif
    files:
      - verif/cpu_tb.sv

// ==== files.f ====
+incdir+source
+incdir+verif
source/cpu_pkg.sv
source/cpu_regfile.sv
source/cpu_alu.sv
source/cpu_bus_master.sv
source/cpu_control.sv
source/cpu_top.sv
verif/cpu_tb.sv

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_alu import cpu_pkg::*; (
    input  alu_op_t  op_i,
    output alu_res_t res_o
);

    word_t imm_ext;
    word_t diff;
    word_t bit_sel;

    assign imm_ext = `CPU_DAT_WIDTH'(op_i.imm);
    assign diff    = op_i.dst_val - imm_ext;
    // tested bit ends up in position 0
    assign bit_sel = op_i.dst_val >> op_i.imm;

    always_comb begin
        res_o = '0;
        case (op_i.opcode)
            OP_SET: begin
                res_o.we = 1'b1;
                if (op_i.format == FMT_RRO) begin
                    res_o.result = op_i.src_val;
                end else begin
                    res_o.result = imm_ext << op_i.shift;
                end
            end
            OP_ADD: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val + imm_ext;
            end
            OP_SUB: begin
                res_o.we      = 1'b1;
                res_o.result  = diff;
                res_o.flag_we = 1'b1;
                res_o.flag    = (diff == '0);
            end
            OP_SHIFTL: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val << op_i.imm;
            end
            OP_SHIFTR: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val >> op_i.imm;
            end
            OP_OR: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val | op_i.src_val;
            end
            OP_AND: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val & op_i.src_val;
            end
            OP_XOR: begin
                res_o.we     = 1'b1;
                res_o.result = op_i.dst_val ^ op_i.src_val;
            end
            OP_JUMP: begin
                res_o.we    = 1'b1;
                res_o.pc_we = 1'b1;
                if (op_i.format == FMT_I) begin
                    res_o.result = `CPU_DAT_WIDTH'(op_i.imm_long);
                end else begin
                    res_o.result = op_i.dst_val;
                end
            end
            OP_TESTBIT: begin
                // flag set means the bit is clear
                res_o.flag_we = 1'b1;
                res_o.flag    = ~bit_sel[0];
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

// ==== source/cpu_bus_master.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_bus_master import cpu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // request side, one transaction at a time
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o,

    // wishbone master
    output logic     cyc_o,
    output logic     stb_o,
    output logic     we_o,
    output sel_t     sel_o,
    output word_t    adr_o,
    output word_t    dat_o,
    input  logic     ack_i,
    input  logic     err_i,
    input  word_t    dat_i
);

    logic start;
    logic done;

    // new requests are only taken while the bus is idle
    assign start = req_valid_i & ~cyc_o;
    assign done  = cyc_o & (ack_i | err_i);

    ////////////////////////////////////////////////////////////////////////////
    // bus cycle control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cyc_o       <= 1'b0;
            stb_o       <= 1'b0;
            we_o        <= 1'b0;
            sel_o       <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            if (done) begin
                cyc_o       <= 1'b0;
                stb_o       <= 1'b0;
                we_o        <= 1'b0;
                sel_o       <= '0;
                rsp_valid_o <= 1'b1;
            end else if (start) begin
                cyc_o <= 1'b1;
                stb_o <= 1'b1;
                we_o  <= req_i.we;
                // full words only
                sel_o <= {`CPU_SEL_WIDTH{1'b1}};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address, write data and response
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_o <= req_i.adr;
            dat_o <= req_i.dat;
        end
        if (done) begin
            rsp_o.err <= err_i;
            rsp_o.dat <= dat_i;
        end
    end

endmodule

// ==== source/cpu_control.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_control import cpu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // bus master
    output logic     req_valid_o,
    output bus_req_t req_o,
    input  logic     rsp_valid_i,
    input  bus_rsp_t rsp_i,

    // register file
    output logic     rf_we_o,
    output reg_id_t  rf_id_o,
    output word_t    rf_dat_o,
    input  word_t    rf_dat_i,

    // execute unit
    output alu_op_t  alu_op_o,
    input  alu_res_t alu_res_i
);

    typedef enum logic [2:0] {
        ST_HALT,
        ST_INIT,
        ST_FETCH,
        ST_DECODE,
        ST_REG_READ,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK
    } state_e;

    state_e      state;
    instr_t      instr;
    instr_t      fetched;
    word_t       dst_val;
    word_t       src_val;
    word_t       offset;
    logic        zero_flag;
    logic [1:0]  fetch_cnt;
    logic        rd_wait;
    logic        rd_src;

    function automatic logic cond_pass(cond_e cond, logic zero);
        case (cond)
            COND_IF_Z:  return zero;
            COND_IF_NZ: return ~zero;
            default:    return 1'b1;
        endcase
    endfunction

    // first register operand sits at the same bits in both formats
    function automatic reg_id_t dst_id(instr_t ins);
        return ins.body[`CPU_RRO_DST];
    endfunction

    assign fetched = rsp_i.dat;
    assign offset  = `CPU_DAT_WIDTH'(instr.body[`CPU_RRO_OFF]);

    always_comb begin
        alu_op_o.opcode   = instr.opcode;
        alu_op_o.format   = instr.format;
        alu_op_o.imm      = instr.body[`CPU_RIS_IMM];
        alu_op_o.shift    = instr.body[`CPU_RIS_SHL];
        alu_op_o.imm_long = instr.body[`CPU_I_IMM];
        alu_op_o.dst_val  = dst_val;
        alu_op_o.src_val  = src_val;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= ST_INIT;
            req_valid_o <= 1'b0;
            rf_we_o     <= 1'b0;
            rf_id_o     <= reg_id_t'(`CPU_REG_PC);
            zero_flag   <= 1'b0;
            fetch_cnt   <= 2'd2;
            rd_wait     <= 1'b0;
            rd_src      <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            case (state)
                ST_HALT: begin
                    state <= ST_HALT;
                end
                ST_INIT: begin
                    rf_we_o <= 1'b0;
                    rf_id_o <= reg_id_t'(`CPU_REG_PC);
                    state   <= ST_FETCH;
                end
                ST_FETCH: begin
                    if (fetch_cnt != 2'd0) begin
                        fetch_cnt <= fetch_cnt - 2'd1;
                    end else begin
                        fetch_cnt   <= 2'd2;
                        req_valid_o <= 1'b1;
                        req_o.we    <= 1'b0;
                        req_o.adr   <= rf_dat_i;
                        req_o.dat   <= '0;
                        // PC increment goes in while the fetch is on the bus
                        rf_we_o     <= 1'b1;
                        rf_dat_o    <= rf_dat_i + `CPU_INSTR_BYTES;
                        state       <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    rf_we_o <= 1'b0;
                    if (rsp_valid_i) begin
                        instr <= fetched;
                        if (rsp_i.err) begin
                            state <= ST_HALT;
                        end else if (!cond_pass(fetched.cond, zero_flag) ||
                                     fetched.opcode == OP_NOP) begin
                            state <= ST_WRITEBACK;
                        end else if (fetched.format == FMT_I) begin
                            state <= ST_EXECUTE;
                        end else begin
                            rf_id_o <= dst_id(fetched);
                            rd_wait <= 1'b1;
                            rd_src  <= 1'b0;
                            state   <= ST_REG_READ;
                        end
                    end
                end
                ST_REG_READ: begin
                    // one cycle for the read and one to pick up the value
                    if (rd_wait) begin
                        rd_wait <= 1'b0;
                    end else if (!rd_src) begin
                        dst_val <= rf_dat_i;
                        if (instr.format == FMT_RRO) begin
                            rf_id_o <= instr.body[`CPU_RRO_SRC];
                            rd_src  <= 1'b1;
                            rd_wait <= 1'b1;
                        end else begin
                            state <= ST_EXECUTE;
                        end
                    end else begin
                        src_val <= rf_dat_i;
                        rd_src  <= 1'b0;
                        state   <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    case (instr.opcode)
                        OP_LOAD: begin
                            req_valid_o <= 1'b1;
                            req_o.we    <= 1'b0;
                            req_o.adr   <= src_val + offset;
                            req_o.dat   <= '0;
                            state       <= ST_MEM;
                        end
                        OP_STORE: begin
                            req_valid_o <= 1'b1;
                            req_o.we    <= 1'b1;
                            req_o.adr   <= dst_val + offset;
                            req_o.dat   <= src_val;
                            state       <= ST_MEM;
                        end
                        OP_HALT: begin
                            state <= ST_HALT;
                        end
                        default: begin
                            rf_we_o  <= alu_res_i.we;
                            rf_id_o  <= alu_res_i.pc_we ? reg_id_t'(`CPU_REG_PC)
                                                        : dst_id(instr);
                            rf_dat_o <= alu_res_i.result;
                            if (alu_res_i.flag_we) begin
                                zero_flag <= alu_res_i.flag;
                            end
                            state <= ST_WRITEBACK;
                        end
                    endcase
                end
                ST_MEM: begin
                    if (rsp_valid_i) begin
                        if (rsp_i.err) begin
                            state <= ST_HALT;
                        end else begin
                            if (instr.opcode == OP_LOAD) begin
                                rf_we_o  <= 1'b1;
                                rf_id_o  <= instr.body[`CPU_RRO_DST];
                                rf_dat_o <= rsp_i.dat;
                            end
                            state <= ST_WRITEBACK;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    // write lands this cycle and the id points back at the PC
                    rf_we_o   <= 1'b0;
                    rf_id_o   <= reg_id_t'(`CPU_REG_PC);
                    fetch_cnt <= 2'd2;
                    state     <= ST_FETCH;
                end
                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

endmodule

// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////////////////////

`define CPU_DAT_WIDTH   64
`define CPU_SEL_WIDTH   8
`define CPU_REG_COUNT   32

// the PC lives in the last register
`define CPU_REG_PC      31
`define CPU_RESET_PC    64'h800000000000
`define CPU_INSTR_BYTES 8

////////////////////////////////////////////////////////////////////////////
// instruction word
////////////////////////////////////////////////////////////////////////////

`define CPU_OPC_WIDTH   7
`define CPU_FMT_WIDTH   2
`define CPU_COND_WIDTH  4
`define CPU_BODY_WIDTH  51
`define CPU_IMM_WIDTH   41
`define CPU_SHL_WIDTH   5

// RIS body: register, immediate, shift
`define CPU_RIS_REG     50:46
`define CPU_RIS_IMM     45:5
`define CPU_RIS_SHL     4:0

// RRO body: destination, source, offset
`define CPU_RRO_DST     50:46
`define CPU_RRO_SRC     45:41
`define CPU_RRO_OFF     40:0

// I body: one long immediate
`define CPU_I_IMM       50:0

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_DAT_WIDTH-1:0]         word_t;
    typedef logic [`CPU_SEL_WIDTH-1:0]         sel_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_id_t;

    typedef enum logic [`CPU_OPC_WIDTH-1:0] {
        OP_NOP     = 7'h00,
        OP_SET     = 7'h01,
        OP_LOAD    = 7'h02,
        OP_STORE   = 7'h03,
        OP_JUMP    = 7'h04,
        OP_TESTBIT = 7'h05,
        OP_SUB     = 7'h06,
        OP_SHIFTL  = 7'h07,
        OP_OR      = 7'h08,
        OP_AND     = 7'h09,
        OP_XOR     = 7'h0a,
        OP_ADD     = 7'h0b,
        OP_SHIFTR  = 7'h0c,
        OP_HALT    = 7'h7f
    } opcode_e;

    typedef enum logic [`CPU_FMT_WIDTH-1:0] {
        FMT_RRO = 2'd0,
        FMT_RIS = 2'd1,
        FMT_I   = 2'd2
    } format_e;

    // IF_NZ is the IF_Z code with the top bit as inversion
    typedef enum logic [`CPU_COND_WIDTH-1:0] {
        COND_ALWAYS = 4'd0,
        COND_IF_Z   = 4'd1,
        COND_IF_NZ  = 4'd9
    } cond_e;

    typedef struct packed {
        opcode_e                    opcode;
        format_e                    format;
        cond_e                      cond;
        logic [`CPU_BODY_WIDTH-1:0] body;
    } instr_t;

    typedef struct packed {
        logic  we;
        word_t adr;
        word_t dat;
    } bus_req_t;

    typedef struct packed {
        logic  err;
        word_t dat;
    } bus_rsp_t;

    typedef struct packed {
        opcode_e                    opcode;
        format_e                    format;
        logic [`CPU_IMM_WIDTH-1:0]  imm;
        logic [`CPU_SHL_WIDTH-1:0]  shift;
        logic [`CPU_BODY_WIDTH-1:0] imm_long;
        word_t                      dst_val;
        word_t                      src_val;
    } alu_op_t;

    typedef struct packed {
        logic  we;
        logic  pc_we;
        word_t result;
        logic  flag_we;
        logic  flag;
    } alu_res_t;

endpackage

// ==== source/cpu_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile import cpu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    we_i,
    input  reg_id_t id_i,
    input  word_t   dat_i,
    output word_t   dat_o
);

    word_t regs [`CPU_REG_COUNT];

    // single port, a write cycle leaves dat_o untouched
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            // start executing from the boot ROM
            regs[`CPU_REG_PC] <= `CPU_RESET_PC;
        end else if (we_i) begin
            regs[id_i] <= dat_i;
        end else begin
            dat_o <= regs[id_i];
        end
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,

    // wishbone master
    output logic  cyc_o,
    output logic  stb_o,
    output logic  we_o,
    output sel_t  sel_o,
    output word_t adr_o,
    output word_t dat_o,
    input  logic  ack_i,
    input  logic  err_i,
    input  word_t dat_i
);

    logic     req_valid;
    bus_req_t req;
    logic     rsp_valid;
    bus_rsp_t rsp;

    logic     rf_we;
    reg_id_t  rf_id;
    word_t    rf_wdat;
    word_t    rf_rdat;

    alu_op_t  alu_op;
    alu_res_t alu_res;

    cpu_control u_control (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_o (req_valid),
        .req_o       (req),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .rf_we_o     (rf_we),
        .rf_id_o     (rf_id),
        .rf_dat_o    (rf_wdat),
        .rf_dat_i    (rf_rdat),
        .alu_op_o    (alu_op),
        .alu_res_i   (alu_res)
    );

    cpu_regfile u_regfile (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .we_i  (rf_we),
        .id_i  (rf_id),
        .dat_i (rf_wdat),
        .dat_o (rf_rdat)
    );

    cpu_alu u_alu (
        .op_i  (alu_op),
        .res_o (alu_res)
    );

    cpu_bus_master u_bus_master (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .cyc_o       (cyc_o),
        .stb_o       (stb_o),
        .we_o        (we_o),
        .sel_o       (sel_o),
        .adr_o       (adr_o),
        .dat_o       (dat_o),
        .ack_i       (ack_i),
        .err_i       (err_i),
        .dat_i       (dat_i)
    );

endmodule

// ==== verif/cpu_tb_program.svh ====
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

// places one instruction at pc and steps the ISA model over it
task automatic emit(input opcode_e op, input format_e fmt, input cond_e cond,
                    input int ra, input int rb, input word_t imm, input int shl);
    logic [`CPU_BODY_WIDTH-1:0] body;
    word_t                      imm41;
    logic                       runs;
    store_t                     st;
    imm41 = {23'b0, imm[40:0]};
    case (fmt)
        FMT_RIS: body = {ra[4:0], imm[40:0], shl[4:0]};
        FMT_RRO: body = {ra[4:0], rb[4:0], imm[40:0]};
        default: body = imm[50:0];
    endcase
    prog[int'((pc - PC_BASE) >> 3)] = {op, fmt, cond, body};
    exp_fetch.push_back(pc);
    pc = pc + 8;
    case (cond)
        COND_IF_Z:  runs = mflag;
        COND_IF_NZ: runs = ~mflag;
        default:    runs = 1'b1;
    endcase
    if (runs) begin
        case (op)
            OP_SET:     mreg[ra] = (fmt == FMT_RRO) ? mreg[rb] : imm41 << shl;
            OP_ADD:     mreg[ra] = mreg[ra] + imm41;
            OP_SHIFTL:  mreg[ra] = mreg[ra] << imm41;
            OP_SHIFTR:  mreg[ra] = mreg[ra] >> imm41;
            OP_OR:      mreg[ra] = mreg[ra] | mreg[rb];
            OP_AND:     mreg[ra] = mreg[ra] & mreg[rb];
            OP_XOR:     mreg[ra] = mreg[ra] ^ mreg[rb];
            OP_TESTBIT: mflag = ~mreg[ra][imm[5:0]];
            OP_LOAD:    mreg[ra] = fill(mreg[rb] + imm41);
            OP_JUMP:    pc = (fmt == FMT_I) ? {13'b0, imm[50:0]} : mreg[ra];
            OP_SUB: begin
                mreg[ra] = mreg[ra] - imm41;
                mflag    = (mreg[ra] == '0);
            end
            OP_STORE: begin
                st.test = cur_test;
                st.adr  = mreg[ra] + imm41;
                st.dat  = mreg[rb];
                exp_store.push_back(st);
            end
            default: ;
        endcase
    end
endtask

task automatic build_program();
    pc    = PC_BASE;
    mflag = 1'b0;
    for (int i = 0; i < 32; i++) begin
        mreg[i] = '0;
    end
    // unused words halt, with their own address as immediate
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = {OP_HALT, FMT_I, COND_ALWAYS, 51'(PC_BASE + 8 * i)};
    end

    cur_test = 2;
    emit(OP_SET,    FMT_RIS, COND_ALWAYS, 1, 0, STORE_BASE >> 28, 28);
    emit(OP_SET,    FMT_RIS, COND_ALWAYS, 2, 0, 64'h1_2345_6789, 3);
    emit(OP_ADD,    FMT_RIS, COND_ALWAYS, 2, 0, 64'h777, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 2, 64'h00, 0);
    emit(OP_SUB,    FMT_RIS, COND_ALWAYS, 2, 0, 64'h55, 0);
    emit(OP_SHIFTL, FMT_RIS, COND_ALWAYS, 2, 0, 64'd5, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 2, 64'h08, 0);
    emit(OP_SHIFTR, FMT_RIS, COND_ALWAYS, 2, 0, 64'd17, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 2, 64'h10, 0);

    cur_test = 3;
    emit(OP_SET,    FMT_RIS, COND_ALWAYS, 3, 0, 64'hf0f0_f0f0, 12);
    emit(OP_SET,    FMT_RIS, COND_ALWAYS, 4, 0, 64'h3c_3c3c_3c3c, 0);
    emit(OP_SET,    FMT_RRO, COND_ALWAYS, 5, 3, 64'h0, 0);
    emit(OP_OR,     FMT_RRO, COND_ALWAYS, 5, 4, 64'h0, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 5, 64'h18, 0);
    emit(OP_AND,    FMT_RRO, COND_ALWAYS, 3, 4, 64'h0, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 3, 64'h20, 0);
    emit(OP_XOR,    FMT_RRO, COND_ALWAYS, 4, 5, 64'h0, 0);
    emit(OP_STORE,  FMT_RRO, COND_ALWAYS, 1, 4, 64'h28, 0);
    emit(OP_JUMP,   FMT_I,   COND_ALWAYS, 0, 0, PC_BASE + 64'h100, 0);

    cur_test = 4;
    emit(OP_SET,     FMT_RIS, COND_ALWAYS, 6, 0, 64'd3, 0);
    emit(OP_SUB,     FMT_RIS, COND_ALWAYS, 6, 0, 64'd3, 0);
    emit(OP_STORE,   FMT_RRO, COND_IF_Z,   1, 6, 64'h30, 0);
    emit(OP_STORE,   FMT_RRO, COND_IF_NZ,  1, 6, 64'h38, 0);
    emit(OP_SET,     FMT_RIS, COND_ALWAYS, 7, 0, 64'h5, 0);
    emit(OP_TESTBIT, FMT_RIS, COND_ALWAYS, 7, 0, 64'd2, 0);
    emit(OP_STORE,   FMT_RRO, COND_IF_Z,   1, 7, 64'h40, 0);
    emit(OP_STORE,   FMT_RRO, COND_IF_NZ,  1, 7, 64'h48, 0);
    emit(OP_TESTBIT, FMT_RIS, COND_ALWAYS, 7, 0, 64'd1, 0);
    emit(OP_STORE,   FMT_RRO, COND_IF_Z,   1, 7, 64'h50, 0);
    emit(OP_SET,     FMT_RIS, COND_ALWAYS, 8, 0, (PC_BASE + 64'h180) >> 7, 7);
    emit(OP_JUMP,    FMT_RIS, COND_IF_NZ,  8, 0, 64'h0, 0);
    emit(OP_JUMP,    FMT_RIS, COND_ALWAYS, 8, 0, 64'h0, 0);

    cur_test = 5;
    emit(OP_SET,   FMT_RIS, COND_ALWAYS, 9, 0, LOAD_BASE >> 28, 28);
    emit(OP_LOAD,  FMT_RRO, COND_ALWAYS, 10, 9, 64'h40, 0);
    emit(OP_STORE, FMT_RRO, COND_ALWAYS, 1, 10, 64'h58, 0);
    emit(OP_LOAD,  FMT_RRO, COND_ALWAYS, 11, 9, 64'h88, 0);
    emit(OP_STORE, FMT_RRO, COND_ALWAYS, 1, 11, 64'h60, 0);
    emit(OP_HALT,  FMT_I,   COND_ALWAYS, 0, 0, 64'h0, 0);
endtask

`endif

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam word_t PC_BASE     = `CPU_RESET_PC;
    localparam word_t STORE_BASE  = 64'h1000_0000;
    localparam word_t LOAD_BASE   = 64'h2000_0000;
    localparam int    PROG_WORDS  = 64;
    localparam int    IDLE_CYCLES = 50;
    localparam sel_t  ALL_BYTES   = 8'hff;

    typedef struct packed {
        int    test;
        word_t adr;
        word_t dat;
    } store_t;

    logic   clk;
    logic   rst;
    logic   cyc;
    logic   stb;
    logic   we;
    sel_t   sel;
    word_t  adr;
    word_t  wdat;
    logic   ack;
    logic   err;
    word_t  rdat;

    // program image and the ISA model that fills the expected queues
    word_t  prog [PROG_WORDS];
    word_t  exp_fetch [$];
    store_t exp_store [$];
    word_t  mreg [32];
    logic   mflag;
    word_t  pc;
    int     cur_test;

    integer seed;
    int     delay;
    logic   pending;
    logic   halted;
    logic   err_run;
    int     cycles;
    int     limit;
    int     test_errs [1:6];
    bit     reported [1:6];
    string  names [1:6];

    // data region contents that depend on every address bit
    function automatic word_t fill(input word_t a);
        return {a[31:0], a[63:32]} ^ (a << 11) ^ 64'h6c0f_93a5_5a3c_e1d7;
    endfunction

    task automatic add_error(input int t);
        test_errs[t] = test_errs[t] + 1;
    endtask

    task automatic report_test(input int t);
        if (!reported[t]) begin
            reported[t] = 1'b1;
            $display("test %0d %s: %0d errors", t, names[t], test_errs[t]);
        end
    endtask

`include "cpu_tb_program.svh"

    initial clk = 1'b0;
    always #50 clk = ~clk;

    cpu_top u_cpu_top (
        .clk_i (clk),
        .rst_i (rst),
        .cyc_o (cyc),
        .stb_o (stb),
        .we_o  (we),
        .sel_o (sel),
        .adr_o (adr),
        .dat_o (wdat),
        .ack_i (ack),
        .err_i (err),
        .dat_i (rdat)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    task automatic respond();
        store_t want;
        word_t  ins;
        // every transfer is a full word
        assert (sel == ALL_BYTES) else begin
            $display("ERR sel_o: expected %h, got %h", ALL_BYTES, sel);
            add_error(5);
        end
        if (we) begin
            if (exp_store.size() == 0) begin
                $display("store of %h to %h that no instruction should make", wdat, adr);
                add_error(4);
            end else begin
                want = exp_store.pop_front();
                assert (adr == want.adr) else begin
                    $display("ERR adr_o: expected %h, got %h", want.adr, adr);
                    add_error(want.test);
                end
                assert (wdat == want.dat) else begin
                    $display("ERR dat_o: expected %h, got %h", want.dat, wdat);
                    add_error(want.test);
                end
                if (exp_store.size() == 0 || exp_store[0].test != want.test) begin
                    report_test(want.test);
                end
            end
            ack = 1'b1;
        end else if (adr >= PC_BASE && adr < PC_BASE + 8 * PROG_WORDS) begin
            if (err_run) begin
                assert (adr == PC_BASE) else begin
                    $display("ERR adr_o: expected %h, got %h", PC_BASE, adr);
                    add_error(6);
                end
                err    = 1'b1;
                halted = 1'b1;
            end else begin
                if (exp_fetch.size() == 0) begin
                    $display("fetch from %h after the program ended", adr);
                    add_error(1);
                end else begin
                    assert (adr == exp_fetch[0]) else begin
                        $display("ERR adr_o: expected fetch %h, got %h", exp_fetch[0], adr);
                        add_error(1);
                    end
                    exp_fetch.delete(0);
                    if (exp_fetch.size() == 0) begin
                        report_test(1);
                    end
                end
                ins  = prog[int'((adr - PC_BASE) >> 3)];
                rdat = ins;
                ack  = 1'b1;
                if (ins[63:57] == OP_HALT) begin
                    halted = 1'b1;
                end
            end
        end else begin
            rdat = fill(adr);
            ack  = 1'b1;
        end
    endtask

    // sample and drive 10 ns after the edge with a random wait of 0 to 3 cycles
    always @(posedge clk) begin
        #10;
        if (rst || ack || err) begin
            ack     = 1'b0;
            err     = 1'b0;
            pending = 1'b0;
        end else if (cyc && stb) begin
            if (!pending) begin
                delay   = $unsigned($random(seed)) % 4;
                pending = 1'b1;
            end
            if (delay == 0) begin
                pending = 1'b0;
                respond();
            end else begin
                delay = delay - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus rules and watchdog
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) stb && !ack && !err |=> stb)
    else begin
        $display("stb_o dropped before ack_i or err_i at %0t", $time);
        add_error(5);
    end

    assert property (@(posedge clk) disable iff (rst) halted && !ack && !err |-> !cyc)
    else begin
        $display("bus cycle started after the core stopped at %0t", $time);
        add_error(6);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("run stopped after %0d cycles without reaching halt", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #10;
        rst    = 1'b1;
        halted = 1'b0;
        cycles = 0;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
    endtask

    initial begin
        int total;
        int clean;
        seed    = 32'h4968;
        rst     = 1'b1;
        ack     = 1'b0;
        err     = 1'b0;
        rdat    = '0;
        pending = 1'b0;
        delay   = 0;
        halted  = 1'b0;
        err_run = 1'b0;
        cycles  = 0;
        names[1] = "fetch order";
        names[2] = "arithmetic and shifts";
        names[3] = "logic and moves";
        names[4] = "conditions";
        names[5] = "load and back-pressure";
        names[6] = "termination";
        for (int t = 1; t <= 6; t++) begin
            test_errs[t] = 0;
            reported[t]  = 1'b0;
        end
        build_program();
        limit = 40 * exp_fetch.size() + 200;

        // program run up to halt
        apply_reset();
        while (!halted) @(posedge clk);
        repeat (IDLE_CYCLES) @(posedge clk);
        if (exp_fetch.size() != 0) begin
            $display("%0d fetches never appeared on the bus", exp_fetch.size());
            add_error(1);
        end
        if (exp_store.size() != 0) begin
            $display("%0d expected stores never appeared on the bus", exp_store.size());
            add_error(exp_store[0].test);
        end
        for (int t = 1; t <= 5; t++) begin
            report_test(t);
        end

        // second run where the first fetch ends in a bus error
        err_run = 1'b1;
        apply_reset();
        while (!halted) @(posedge clk);
        repeat (IDLE_CYCLES) @(posedge clk);
        report_test(6);

        total = 0;
        clean = 0;
        for (int t = 1; t <= 6; t++) begin
            total = total + test_errs[t];
            if (test_errs[t] == 0) begin
                clean = clean + 1;
            end
        end
        $display("summary: %0d of 6 tests clean, %0d errors", clean, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
